// ==== hw/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and field widths
`define CPU_XLEN 32
`define CPU_REG_BITS 5
`define CPU_IMM_BITS 17
`define CPU_TGT_BITS 27
`define CPU_OPC_BITS 5

// low bit of each instruction field
`define CPU_OPC_LSB 27
`define CPU_RD_LSB 22
`define CPU_RS_LSB 17
`define CPU_RT_LSB 12
`define CPU_SHAMT_LSB 7
`define CPU_FUNC_LSB 2

// opcodes
`define CPU_OP_ALU 5'd0
`define CPU_OP_J 5'd1
`define CPU_OP_BNE 5'd2
`define CPU_OP_JAL 5'd3
`define CPU_OP_JR 5'd4
`define CPU_OP_ADDI 5'd5
`define CPU_OP_BLT 5'd6
`define CPU_OP_SW 5'd7
`define CPU_OP_LW 5'd8

// alu function codes, unsized so they fit the 3-bit enum and the 5-bit field
`define CPU_ALU_ADD 0
`define CPU_ALU_SUB 1
`define CPU_ALU_AND 2
`define CPU_ALU_OR 3
`define CPU_ALU_SLL 4
`define CPU_ALU_SRA 5

// jal return address register
`define CPU_REG_LINK 5'd31

`endif

// ==== hw/cpuPkg.sv ====
`include "cpu_defs.svh"

package cpuPkg;

    // alu operations, encoded as in the instruction's alu op field
    typedef enum logic [2:0] {
        ALU_ADD = `CPU_ALU_ADD,
        ALU_SUB = `CPU_ALU_SUB,
        ALU_AND = `CPU_ALU_AND,
        ALU_OR = `CPU_ALU_OR,
        ALU_SLL = `CPU_ALU_SLL,
        ALU_SRA = `CPU_ALU_SRA
    } aluOpT;

    // which value goes back to the register file
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_LINK = 2'd2
    } wbSrcT;

    // decoded control, all zero means no operation
    typedef struct packed {
        // already cleared for r0 destinations
        logic regWrEn;
        logic memWr;
        logic memRd;
        aluOpT aluOp;
        logic aluUsesImm;
        wbSrcT wbSrc;
        logic isBne;
        logic isBlt;
        // j and jal
        logic isJump;
        logic isJr;
    } ctrlT;

    // register file ports
    typedef struct packed {
        logic [`CPU_REG_BITS-1:0] regA;
        logic [`CPU_REG_BITS-1:0] regB;
    } rfReadT;

    typedef struct packed {
        logic en;
        logic [`CPU_REG_BITS-1:0] wrReg;
        logic [`CPU_XLEN-1:0] data;
    } rfWriteT;

    // data memory request, read is combinational at addr
    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wrData;
        logic wrEn;
    } dmemReqT;

    // fetch to decode
    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;
    } fdT;

    // decode to execute
    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] opA;
        logic [`CPU_XLEN-1:0] opB;
        logic [`CPU_XLEN-1:0] imm;
        logic [`CPU_XLEN-1:0] target;
        // source indices kept for forwarding
        logic [`CPU_REG_BITS-1:0] srcA;
        logic [`CPU_REG_BITS-1:0] srcB;
        logic [`CPU_REG_BITS-1:0] dest;
        logic [`CPU_REG_BITS-1:0] shamt;
        ctrlT ctrl;
    } dxT;

    // execute to memory, result is alu output or link address
    typedef struct packed {
        logic [`CPU_XLEN-1:0] result;
        logic [`CPU_XLEN-1:0] storeData;
        logic [`CPU_REG_BITS-1:0] dest;
        ctrlT ctrl;
    } xmT;

    // memory to writeback, result already holds load data
    typedef struct packed {
        logic [`CPU_XLEN-1:0] result;
        logic [`CPU_REG_BITS-1:0] dest;
        ctrlT ctrl;
    } mwT;

endpackage

// ==== hw/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input logic clock,
    input logic arstN,
    input logic hold,
    input logic bubble,
    input payloadT d,
    output payloadT q
);

    // all-zero payload carries an all-zero ctrl, so it acts as a nop
    localparam payloadT BUBBLE = payloadT'('0);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            q <= BUBBLE;
        end else if (bubble) begin
            // bubble beats hold when flushing during a stall
            q <= BUBBLE;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// ==== hw/decoder.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decoder (
    input logic [`CPU_XLEN-1:0] instr,
    output cpuPkg::rfReadT rfRead,
    output cpuPkg::ctrlT ctrl,
    output logic [`CPU_REG_BITS-1:0] dest,
    output logic [`CPU_REG_BITS-1:0] shamt,
    output logic [`CPU_XLEN-1:0] imm,
    output logic [`CPU_XLEN-1:0] target,
    output logic readsA,
    output logic readsB
);

    logic [`CPU_OPC_BITS-1:0] opcode;
    logic [`CPU_REG_BITS-1:0] rd;
    logic [`CPU_REG_BITS-1:0] rs;
    logic [`CPU_REG_BITS-1:0] rt;
    logic [`CPU_REG_BITS-1:0] func;
    logic [`CPU_IMM_BITS-1:0] immField;
    logic [`CPU_TGT_BITS-1:0] tgtField;
    logic isBranch;
    logic rdOnB;

    // raw fields
    assign opcode = instr[`CPU_OPC_LSB +: `CPU_OPC_BITS];
    assign rd = instr[`CPU_RD_LSB +: `CPU_REG_BITS];
    assign rs = instr[`CPU_RS_LSB +: `CPU_REG_BITS];
    assign rt = instr[`CPU_RT_LSB +: `CPU_REG_BITS];
    assign shamt = instr[`CPU_SHAMT_LSB +: `CPU_REG_BITS];
    assign func = instr[`CPU_FUNC_LSB +: `CPU_REG_BITS];
    assign immField = instr[`CPU_IMM_BITS-1:0];
    assign tgtField = instr[`CPU_TGT_BITS-1:0];

    // immediate is signed, target is an absolute word address
    assign imm = {{(`CPU_XLEN-`CPU_IMM_BITS){immField[`CPU_IMM_BITS-1]}}, immField};
    assign target = {{(`CPU_XLEN-`CPU_TGT_BITS){1'b0}}, tgtField};

    // jal writes its link to r31, everything else to rd
    assign dest = (opcode == `CPU_OP_JAL) ? `CPU_REG_LINK : rd;

    // branches compare rd against rs
    assign isBranch = (opcode == `CPU_OP_BNE) || (opcode == `CPU_OP_BLT);
    // sw stores rd and jr jumps to rd, both through port B
    assign rdOnB = (opcode == `CPU_OP_SW) || (opcode == `CPU_OP_JR);
    assign rfRead.regA = isBranch ? rd : rs;
    assign rfRead.regB = isBranch ? rs : (rdOnB ? rd : rt);

    always_comb begin
        ctrl = '0;
        readsA = 1'b0;
        readsB = 1'b0;
        case (opcode)
            `CPU_OP_ALU: begin
                // unknown function codes stay a nop
                if (func <= `CPU_ALU_SRA) begin
                    ctrl.regWrEn = 1'b1;
                    ctrl.aluOp = cpuPkg::aluOpT'(func[2:0]);
                    readsA = 1'b1;
                    // shifts take their amount from shamt, not rt
                    readsB = (func != `CPU_ALU_SLL) && (func != `CPU_ALU_SRA);
                end
            end
            `CPU_OP_ADDI: begin
                ctrl.regWrEn = 1'b1;
                ctrl.aluUsesImm = 1'b1;
                readsA = 1'b1;
            end
            `CPU_OP_LW: begin
                ctrl.regWrEn = 1'b1;
                ctrl.memRd = 1'b1;
                ctrl.aluUsesImm = 1'b1;
                ctrl.wbSrc = cpuPkg::WB_MEM;
                readsA = 1'b1;
            end
            `CPU_OP_SW: begin
                ctrl.memWr = 1'b1;
                ctrl.aluUsesImm = 1'b1;
                readsA = 1'b1;
                readsB = 1'b1;
            end
            `CPU_OP_BNE: begin
                ctrl.isBne = 1'b1;
                readsA = 1'b1;
                readsB = 1'b1;
            end
            `CPU_OP_BLT: begin
                ctrl.isBlt = 1'b1;
                readsA = 1'b1;
                readsB = 1'b1;
            end
            `CPU_OP_J: begin
                ctrl.isJump = 1'b1;
            end
            `CPU_OP_JAL: begin
                ctrl.isJump = 1'b1;
                ctrl.regWrEn = 1'b1;
                ctrl.wbSrc = cpuPkg::WB_LINK;
            end
            `CPU_OP_JR: begin
                ctrl.isJr = 1'b1;
                readsB = 1'b1;
            end
            default: begin
                // unknown opcode, nothing happens
                ctrl = '0;
            end
        endcase
        // r0 is never written
        if (dest == '0) begin
            ctrl.regWrEn = 1'b0;
        end
    end

endmodule

// ==== hw/hazardUnit.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module hazardUnit (
    input cpuPkg::rfReadT rfRead,
    input logic readsA,
    input logic readsB,
    input cpuPkg::dxT dx,
    input cpuPkg::xmT xm,
    input cpuPkg::mwT mw,
    output logic [1:0] fwdSelA,
    output logic [1:0] fwdSelB,
    output logic stall
);

    logic loadInEx;
    logic hitA;
    logic hitB;

    // select codes: 0 decoded value, 1 from xm, 2 from mw
    function automatic logic [1:0] pickFwd(
        input logic [`CPU_REG_BITS-1:0] src,
        input cpuPkg::xmT xmIn,
        input cpuPkg::mwT mwIn
    );
        logic [1:0] sel;
        sel = 2'd0;
        // a load in xm has no data yet, the stall keeps it from being needed
        if (xmIn.ctrl.regWrEn && !xmIn.ctrl.memRd && (xmIn.dest == src)) begin
            sel = 2'd1;
        end else if (mwIn.ctrl.regWrEn && (mwIn.dest == src)) begin
            sel = 2'd2;
        end
        return sel;
    endfunction

    // youngest producer wins
    assign fwdSelA = pickFwd(dx.srcA, xm, mw);
    assign fwdSelB = pickFwd(dx.srcB, xm, mw);

    // load in execute whose result the decoding instruction needs
    assign loadInEx = dx.ctrl.memRd && dx.ctrl.regWrEn;
    // unused read ports never stall
    assign hitA = readsA && (rfRead.regA == dx.dest);
    assign hitB = readsB && (rfRead.regB == dx.dest);
    assign stall = loadInEx && (hitA || hitB);

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
    input logic [`CPU_XLEN-1:0] a,
    input logic [`CPU_XLEN-1:0] b,
    input cpuPkg::aluOpT op,
    input logic [`CPU_REG_BITS-1:0] shamt,
    output logic [`CPU_XLEN-1:0] result,
    output logic isNe,
    output logic isLt
);

    always_comb begin
        case (op)
            cpuPkg::ALU_ADD: begin
                result = a + b;
            end
            cpuPkg::ALU_SUB: begin
                result = a - b;
            end
            cpuPkg::ALU_AND: begin
                result = a & b;
            end
            cpuPkg::ALU_OR: begin
                result = a | b;
            end
            // shifts use shamt and ignore b
            cpuPkg::ALU_SLL: begin
                result = a << shamt;
            end
            cpuPkg::ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branch flags, a is rd and b is rs for bne and blt
    assign isNe = (a != b);
    assign isLt = ($signed(a) < $signed(b));

endmodule

// ==== hw/processor.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module processor (
    input logic clock,
    input logic arstN,
    output logic [`CPU_XLEN-1:0] imemAddr,
    input logic [`CPU_XLEN-1:0] imemData,
    output cpuPkg::dmemReqT dmemReq,
    input logic [`CPU_XLEN-1:0] dmemRdData,
    output cpuPkg::rfReadT rfRead,
    input logic [`CPU_XLEN-1:0] rfRdDataA,
    input logic [`CPU_XLEN-1:0] rfRdDataB,
    output cpuPkg::rfWriteT rfWrite
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] nextPc;
    logic [`CPU_XLEN-1:0] pcPlus1;
    logic stall;
    logic redirect;
    logic [`CPU_XLEN-1:0] redirectPc;

    cpuPkg::fdT fdIn;
    cpuPkg::fdT fd;
    cpuPkg::dxT dxIn;
    cpuPkg::dxT dx;
    cpuPkg::xmT xmIn;
    cpuPkg::xmT xm;
    cpuPkg::mwT mwIn;
    cpuPkg::mwT mw;

    // decode outputs
    cpuPkg::ctrlT decCtrl;
    logic [`CPU_REG_BITS-1:0] decDest;
    logic [`CPU_REG_BITS-1:0] decShamt;
    logic [`CPU_XLEN-1:0] decImm;
    logic [`CPU_XLEN-1:0] decTarget;
    logic readsA;
    logic readsB;

    // execute signals
    logic [1:0] fwdSelA;
    logic [1:0] fwdSelB;
    logic [`CPU_XLEN-1:0] fwdA;
    logic [`CPU_XLEN-1:0] fwdB;
    logic [`CPU_XLEN-1:0] aluB;
    logic [`CPU_XLEN-1:0] aluResult;
    logic [`CPU_XLEN-1:0] exPcPlus1;
    logic isNe;
    logic isLt;
    logic branchTaken;

    // fetch
    assign imemAddr = pc;
    assign pcPlus1 = pc + `CPU_XLEN'(1);
    // redirect beats the load-use hold
    assign nextPc = redirect ? redirectPc : (stall ? pc : pcPlus1);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    assign fdIn.pc = pc;
    assign fdIn.instr = imemData;

    stageReg #(.payloadT(cpuPkg::fdT)) fdStage (
        .clock(clock),
        .arstN(arstN),
        .hold(stall),
        .bubble(redirect),
        .d(fdIn),
        .q(fd)
    );

    // decode, register file answers combinationally
    decoder decode0 (
        .instr(fd.instr),
        .rfRead(rfRead),
        .ctrl(decCtrl),
        .dest(decDest),
        .shamt(decShamt),
        .imm(decImm),
        .target(decTarget),
        .readsA(readsA),
        .readsB(readsB)
    );

    assign dxIn.pc = fd.pc;
    assign dxIn.opA = rfRdDataA;
    assign dxIn.opB = rfRdDataB;
    assign dxIn.imm = decImm;
    assign dxIn.target = decTarget;
    assign dxIn.srcA = rfRead.regA;
    assign dxIn.srcB = rfRead.regB;
    assign dxIn.dest = decDest;
    assign dxIn.shamt = decShamt;
    assign dxIn.ctrl = decCtrl;

    // a stall leaves a bubble behind the load
    stageReg #(.payloadT(cpuPkg::dxT)) dxStage (
        .clock(clock),
        .arstN(arstN),
        .hold(1'b0),
        .bubble(redirect || stall),
        .d(dxIn),
        .q(dx)
    );

    hazardUnit hazard0 (
        .rfRead(rfRead),
        .readsA(readsA),
        .readsB(readsB),
        .dx(dx),
        .xm(xm),
        .mw(mw),
        .fwdSelA(fwdSelA),
        .fwdSelB(fwdSelB),
        .stall(stall)
    );

    // execute operand muxes
    always_comb begin
        case (fwdSelA)
            2'd1: fwdA = xm.result;
            2'd2: fwdA = mw.result;
            default: fwdA = dx.opA;
        endcase
        case (fwdSelB)
            2'd1: fwdB = xm.result;
            2'd2: fwdB = mw.result;
            default: fwdB = dx.opB;
        endcase
    end

    assign aluB = dx.ctrl.aluUsesImm ? dx.imm : fwdB;

    alu alu0 (
        .a(fwdA),
        .b(aluB),
        .op(dx.ctrl.aluOp),
        .shamt(dx.shamt),
        .result(aluResult),
        .isNe(isNe),
        .isLt(isLt)
    );

    // branch and jump resolution
    assign exPcPlus1 = dx.pc + `CPU_XLEN'(1);
    assign branchTaken = (dx.ctrl.isBne && isNe) || (dx.ctrl.isBlt && isLt);
    assign redirect = branchTaken || dx.ctrl.isJump || dx.ctrl.isJr;

    always_comb begin
        if (dx.ctrl.isJr) begin
            // jr target is the forwarded rd value
            redirectPc = fwdB;
        end else if (dx.ctrl.isJump) begin
            redirectPc = dx.target;
        end else begin
            redirectPc = exPcPlus1 + dx.imm;
        end
    end

    // jal carries its link address in the result field
    assign xmIn.result = (dx.ctrl.wbSrc == cpuPkg::WB_LINK) ? exPcPlus1 : aluResult;
    assign xmIn.storeData = fwdB;
    assign xmIn.dest = dx.dest;
    assign xmIn.ctrl = dx.ctrl;

    stageReg #(.payloadT(cpuPkg::xmT)) xmStage (
        .clock(clock),
        .arstN(arstN),
        .hold(1'b0),
        .bubble(1'b0),
        .d(xmIn),
        .q(xm)
    );

    // memory
    assign dmemReq.addr = xm.result;
    assign dmemReq.wrData = xm.storeData;
    assign dmemReq.wrEn = xm.ctrl.memWr;

    assign mwIn.result = xm.ctrl.memRd ? dmemRdData : xm.result;
    assign mwIn.dest = xm.dest;
    assign mwIn.ctrl = xm.ctrl;

    stageReg #(.payloadT(cpuPkg::mwT)) mwStage (
        .clock(clock),
        .arstN(arstN),
        .hold(1'b0),
        .bubble(1'b0),
        .d(mwIn),
        .q(mw)
    );

    // writeback
    assign rfWrite.en = mw.ctrl.regWrEn;
    assign rfWrite.wrReg = mw.dest;
    assign rfWrite.data = mw.result;

endmodule

// ==== testbench/tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    logic fb;
    int i;
    value = '0;
    for (i = 0; i < count; i++) begin
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        value = {value[30:0], fb};
    end
    return value;
endfunction

// working registers r0..r7
function automatic logic [4:0] pickReg();
    return 5'(randBits(3));
endfunction

// half the time reuse the last destination to build dependences
function automatic logic [4:0] pickSrc(input logic [4:0] recent);
    return (randBits(1) != 0) ? recent : pickReg();
endfunction

function automatic logic [31:0] encodeR(input logic [4:0] func, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] shamt);
    return {`CPU_OP_ALU, rd, rs, rt, shamt, func, 2'b00};
endfunction

function automatic logic [31:0] encodeI(input logic [4:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [16:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic logic [31:0] encodeJ(input logic [4:0] op, input logic [26:0] target);
    return {op, target};
endfunction

// data memory start value, mixes every address bit
function automatic logic [31:0] memFill(input int idx);
    return {16'hd0a0, 16'(idx)} ^ (32'(idx) * 32'h0100_0193);
endfunction

// random program, every control transfer goes forward so it always ends
function automatic void buildProgram();
    int pc;
    int room;
    int span;
    int kind;
    int target;
    int i;
    logic [4:0] rd;
    logic [4:0] srcA;
    logic [4:0] srcB;
    logic [4:0] lastDest;
    pc = 0;
    lastDest = 5'd1;
    for (i = 0; i < PROG_LEN; i++) begin
        tgtMark[i] = 1'b0;
    end
    while (pc < HALT_PC) begin
        room = HALT_PC - pc;
        kind = int'(randBits(4));
        rd = pickReg();
        srcA = pickSrc(lastDest);
        srcB = pickSrc(lastDest);
        // a jr must never be a landing point, its addi would be skipped
        if (kind == 15 && (room < 2 || tgtMark[pc + 1])) begin
            kind = 6;
        end
        if (kind < 6) begin
            progMem[pc] = encodeR(5'(randBits(3) % 6), rd, srcA, srcB, 5'(randBits(5)));
            lastDest = rd;
            pc++;
        end else if (kind < 9) begin
            progMem[pc] = encodeI(`CPU_OP_ADDI, rd, srcA, 17'(randBits(17)));
            lastDest = rd;
            pc++;
        end else if (kind < 11) begin
            progMem[pc] = encodeI(`CPU_OP_LW, rd, 5'd0, 17'(randBits(6)));
            lastDest = rd;
            pc++;
            if (room >= 2 && randBits(1) != 0) begin
                // store of the register just loaded, forces the load-use stall
                progMem[pc] = encodeI(`CPU_OP_SW, rd, 5'd0, 17'(randBits(6)));
                pc++;
            end
        end else if (kind < 13) begin
            progMem[pc] = encodeI(`CPU_OP_SW, srcA, 5'd0, 17'(randBits(6)));
            pc++;
        end else if (kind == 13) begin
            span = int'(randBits(3)) % room;
            progMem[pc] = encodeI((randBits(1) != 0) ? `CPU_OP_BNE : `CPU_OP_BLT,
                                  srcA, rd, 17'(span));
            tgtMark[pc + 1 + span] = 1'b1;
            pc++;
        end else if (kind == 14) begin
            span = int'(randBits(3)) % room;
            progMem[pc] = encodeJ((randBits(1) != 0) ? `CPU_OP_JAL : `CPU_OP_J,
                                  27'(pc + 1 + span));
            tgtMark[pc + 1 + span] = 1'b1;
            pc++;
        end else begin
            // addi loads the target, jr follows at once
            span = int'(randBits(3)) % (room - 1);
            target = pc + 2 + span;
            rd = 5'd1 + 5'(randBits(3) % 7);
            progMem[pc] = encodeI(`CPU_OP_ADDI, rd, 5'd0, 17'(target));
            progMem[pc + 1] = encodeI(`CPU_OP_JR, rd, 5'd0, 17'd0);
            tgtMark[target] = 1'b1;
            lastDest = rd;
            pc += 2;
        end
    end
    // halt is a jump to itself
    progMem[HALT_PC] = encodeJ(`CPU_OP_J, 27'(HALT_PC));
endfunction

function automatic logic [31:0] aluModel(input logic [4:0] fn, input logic [31:0] a,
                                         input logic [31:0] b, input logic [4:0] sh);
    logic [31:0] res;
    case (fn)
        5'(`CPU_ALU_ADD): res = a + b;
        5'(`CPU_ALU_SUB): res = a - b;
        5'(`CPU_ALU_AND): res = a & b;
        5'(`CPU_ALU_OR): res = a | b;
        5'(`CPU_ALU_SLL): res = a << sh;
        5'(`CPU_ALU_SRA): res = $signed(a) >>> sh;
        default: res = '0;
    endcase
    return res;
endfunction

// r0 stays zero and is never part of the write sequence
function automatic void writeModelReg(input logic [4:0] idx, input logic [31:0] value);
    if (idx != 5'd0) begin
        modelRegs[idx] = value;
        expWrReg.push_back(idx);
        expWrData.push_back(value);
    end
endfunction

// runs the program one instruction at a time
function automatic void runModel();
    int pc;
    int nextPc;
    int steps;
    logic [31:0] ins;
    logic [4:0] rd;
    logic [4:0] rs;
    logic [31:0] imm;
    logic [31:0] addr;
    pc = 0;
    steps = 0;
    modelDone = 1'b0;
    while (!modelDone && steps < MODEL_STEPS && pc < PROG_LEN) begin
        ins = progMem[pc];
        rd = ins[26:22];
        rs = ins[21:17];
        imm = {{15{ins[16]}}, ins[16:0]};
        addr = modelRegs[rs] + imm;
        nextPc = pc + 1;
        case (ins[31:27])
            `CPU_OP_ALU: begin
                writeModelReg(rd, aluModel(ins[6:2], modelRegs[rs], modelRegs[ins[16:12]],
                                           ins[11:7]));
            end
            `CPU_OP_ADDI: writeModelReg(rd, addr);
            `CPU_OP_LW: writeModelReg(rd, modelMem[addr[5:0]]);
            `CPU_OP_SW: begin
                modelMem[addr[5:0]] = modelRegs[rd];
                expStAddr.push_back(addr);
                expStData.push_back(modelRegs[rd]);
            end
            `CPU_OP_BNE: begin
                if (modelRegs[rd] != modelRegs[rs]) begin
                    nextPc = pc + 1 + int'($signed(imm));
                end
            end
            `CPU_OP_BLT: begin
                if ($signed(modelRegs[rd]) < $signed(modelRegs[rs])) begin
                    nextPc = pc + 1 + int'($signed(imm));
                end
            end
            `CPU_OP_J: begin
                nextPc = int'({5'd0, ins[26:0]});
                modelDone = (nextPc == pc);
            end
            `CPU_OP_JAL: begin
                writeModelReg(`CPU_REG_LINK, 32'(pc + 1));
                nextPc = int'({5'd0, ins[26:0]});
            end
            `CPU_OP_JR: nextPc = int'(modelRegs[rd]);
            default: nextPc = pc + 1;
        endcase
        pc = nextPc;
        steps++;
    end
endfunction

`endif

// ==== testbench/tbProcessor.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tbProcessor;

    localparam int PROG_LEN = 160;
    localparam int HALT_PC = PROG_LEN - 1;
    localparam int MODEL_STEPS = 4000;
    localparam int RUN_LIMIT = 4000;
    localparam int RESET_CYCLES = 16;
    localparam int HALT_CYCLES = 8;

    logic clock = 1'b0;
    logic arstN;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] dmemRdData;
    logic [31:0] rfRdDataA;
    logic [31:0] rfRdDataB;
    cpuPkg::dmemReqT dmemReq;
    cpuPkg::rfReadT rfRead;
    cpuPkg::rfWriteT rfWrite;

    // instruction rom, data memory and register file around the DUT
    logic [31:0] progMem [0:PROG_LEN-1];
    logic [31:0] dmem [0:63];
    logic [31:0] regs [0:31];

    // reference model state and its expected event sequences
    logic [31:0] modelRegs [0:31];
    logic [31:0] modelMem [0:63];
    logic modelDone;
    logic tgtMark [0:PROG_LEN-1];
    logic [31:0] lfsrState;
    logic [4:0] expWrReg [$];
    logic [31:0] expWrData [$];
    logic [31:0] expStAddr [$];
    logic [31:0] expStData [$];

    int wrIdx;
    int stIdx;
    logic monitorOn;

    `include "tbModel.svh"

    processor dut0 (
        .clock(clock),
        .arstN(arstN),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .dmemReq(dmemReq),
        .dmemRdData(dmemRdData),
        .rfRead(rfRead),
        .rfRdDataA(rfRdDataA),
        .rfRdDataB(rfRdDataB),
        .rfWrite(rfWrite)
    );

    always #10 clock = ~clock;

    // combinational rom that reads zero past the end of the program
    assign imemData = (imemAddr < 32'(PROG_LEN)) ? progMem[imemAddr[7:0]] : '0;
    assign dmemRdData = dmem[dmemReq.addr[5:0]];

    // write-through reads where r0 always reads as zero
    assign rfRdDataA = (rfRead.regA == 5'd0) ? '0 :
        ((rfWrite.en && rfWrite.wrReg == rfRead.regA) ? rfWrite.data : regs[rfRead.regA]);
    assign rfRdDataB = (rfRead.regB == 5'd0) ? '0 :
        ((rfWrite.en && rfWrite.wrReg == rfRead.regB) ? rfWrite.data : regs[rfRead.regB]);

    always @(posedge clock) begin
        if (rfWrite.en && rfWrite.wrReg != 5'd0) begin
            regs[rfWrite.wrReg] <= rfWrite.data;
        end
        if (dmemReq.wrEn) begin
            dmem[dmemReq.addr[5:0]] <= dmemReq.wrData;
        end
    end

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            stopOnError($sformatf("ERR %s expected %h got %h", name, expected, actual));
        end
    endtask

    // pc held at zero and nothing written while in reset
    task automatic checkReset();
        checkValue("imemAddr", 32'd0, imemAddr);
        checkValue("rfWrite.en", 32'd0, 32'(rfWrite.en));
        checkValue("dmemReq.wrEn", 32'd0, 32'(dmemReq.wrEn));
    endtask

    // register writes and stores follow the model's sequences in order
    always @(negedge clock) begin
        if (monitorOn) begin
            if (rfWrite.en) begin
                assert (rfWrite.wrReg != 5'd0) else begin
                    stopOnError($sformatf("ERR rfWrite.wrReg expected nonzero got %h",
                                          rfWrite.wrReg));
                end
                assert (wrIdx < expWrReg.size()) else begin
                    stopOnError("register write seen after the model's last register write");
                end
                checkValue("rfWrite.wrReg", 32'(expWrReg[wrIdx]), 32'(rfWrite.wrReg));
                checkValue("rfWrite.data", expWrData[wrIdx], rfWrite.data);
                wrIdx++;
            end
            if (dmemReq.wrEn) begin
                assert (stIdx < expStAddr.size()) else begin
                    stopOnError("store seen after the model's last store");
                end
                checkValue("dmemReq.addr", expStAddr[stIdx], dmemReq.addr);
                checkValue("dmemReq.wrData", expStData[stIdx], dmemReq.wrData);
                stIdx++;
            end
        end
    end

    initial begin
        int i;
        int cycles;
        int haltRun;
        arstN = 1'b0;
        wrIdx = 0;
        stIdx = 0;
        monitorOn = 1'b0;
        lfsrState = 32'h5e971914;
        buildProgram();
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
            modelRegs[i] = '0;
        end
        for (i = 0; i < 64; i++) begin
            dmem[i] = memFill(i);
            modelMem[i] = memFill(i);
        end
        runModel();
        assert (modelDone) else begin
            stopOnError("reference model never reached the halt jump");
        end
        $display("program: %0d register writes, %0d stores expected",
                 expWrReg.size(), expStAddr.size());

        repeat (RESET_CYCLES) begin
            @(negedge clock);
            checkReset();
        end
        @(posedge clock);
        arstN <= 1'b1;
        monitorOn = 1'b1;
        // first cycle out of reset still shows the reset state
        @(negedge clock);
        checkReset();

        // halt jump keeps refetching its own address and the two after it
        cycles = 0;
        haltRun = 0;
        while (haltRun < HALT_CYCLES && cycles < RUN_LIMIT) begin
            @(negedge clock);
            cycles++;
            if (imemAddr >= 32'(HALT_PC) && imemAddr <= 32'(HALT_PC + 2)) begin
                haltRun++;
            end else begin
                haltRun = 0;
            end
        end
        assert (haltRun >= HALT_CYCLES) else begin
            stopOnError("timeout, the program never reached the halt jump");
        end

        // all expected events consumed and the final state equal to the model
        checkValue("register write count", 32'(expWrReg.size()), 32'(wrIdx));
        checkValue("store count", 32'(expStAddr.size()), 32'(stIdx));
        for (i = 0; i < 32; i++) begin
            checkValue($sformatf("regs[%0d]", i), modelRegs[i], regs[i]);
        end
        for (i = 0; i < 64; i++) begin
            checkValue($sformatf("dmem[%0d]", i), modelMem[i], dmem[i]);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== processor.f ====
+incdir+hw
+incdir+testbench
hw/cpuPkg.sv
hw/stageReg.sv
hw/decoder.sv
hw/hazardUnit.sv
hw/alu.sv
hw/processor.sv
testbench/tbProcessor.sv

// ==== run.sh ====
#!/bin/sh
# build the processor testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tbProcessor -f processor.f -o simProcessor
./obj_dir/simProcessor | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
